// ==== build.f ====
+incdir+common
common/reg_board_pkg.sv
hdl/microcode_decoder.sv
hdl/major_register.sv
hdl/front_panel_port.sv
hdl/reg_board.sv
tb/reg_board_assert.sv
tb/reg_board_tb.sv

// ==== common/reg_board_pkg.sv ====
// Register board types
// Bus words, microcode fields, strobes and front panel selectors
`include "reg_board_settings.svh"

package reg_board_pkg;

   typedef logic [`REG_WIDTH-1:0]    word_t;     // Register or bus value
   typedef logic [`BYTE_WIDTH-1:0]   byte_t;     // Front panel byte

   typedef logic [`ADDR_WIDTH-1:0]   addr_t;     // Microcode read/write address
   typedef logic [`ACTION_WIDTH-1:0] action_t;   // Microcode action code

   typedef logic [`REG_COUNT-1:0]    strobe_t;   // One bit per register, one-hot or zero

   // Register index, 0 PC, 1 DR, 2 AC, 3 SP
   typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;

   // Front panel select, top bit picks the high byte
   typedef logic [`REG_IDX_WIDTH:0]  fp_sel_t;

   // Front panel handshake states
   typedef enum logic [1:0] {
      FP_IDLE    = 2'd0,                          // Waiting for fp_req
      FP_HOLD    = 2'd1,                          // Ack high, snapshot frozen
      FP_RELEASE = 2'd2                           // Ack dropped, one cycle gap
   } fp_state_t;

endpackage

// ==== common/reg_board_settings.svh ====
// Register board settings
// Widths, register count and microcode decode bases
`ifndef REG_BOARD_SETTINGS_SVH
`define REG_BOARD_SETTINGS_SVH

`define REG_WIDTH      16   // Major register and processor bus width
`define BYTE_WIDTH     8    // Front panel data width
`define REG_COUNT      4    // PC, DR, AC, SP
`define REG_IDX_WIDTH  2    // Enough bits to index REG_COUNT registers

`define ADDR_WIDTH     5    // Microcode read/write address field
`define ACTION_WIDTH   4    // Microcode action field

`define REG_ADDR_BASE  8    // Addresses 8..11 select PC, DR, AC, SP
`define ACTION_BASE    8    // Actions 8..15 belong to this board

`endif

// ==== hdl/front_panel_port.sv ====
// Front panel port
// Four-phase req/ack readout of one byte of any major register
`timescale 1ns/1ps
`include "reg_board_settings.svh"

module front_panel_port (
   input  logic                   clk4,
   input  logic                   rst_n,
   input  logic                   fp_req,     // Host request, four-phase
   input  reg_board_pkg::fp_sel_t fp_sel,     // Register index plus high-byte bit
   input  reg_board_pkg::word_t   pc,
   input  reg_board_pkg::word_t   dr,
   input  reg_board_pkg::word_t   ac,
   input  reg_board_pkg::word_t   sp,
   output logic                   fp_ack,     // Snapshot valid in fpd
   output reg_board_pkg::byte_t   fpd         // Captured byte
);

   reg_board_pkg::fp_state_t state;
   reg_board_pkg::reg_idx_t  sel_idx;
   logic                     sel_high;
   reg_board_pkg::word_t     sel_word;
   reg_board_pkg::byte_t     sel_byte;

   ////////////////////////////////////////////////////////////
   // Byte select
   ////////////////////////////////////////////////////////////

   assign sel_idx  = fp_sel[`REG_IDX_WIDTH-1:0];
   assign sel_high = fp_sel[`REG_IDX_WIDTH];

   always_comb begin
      case (sel_idx)
         2'd0:    sel_word = pc;
         2'd1:    sel_word = dr;
         2'd2:    sel_word = ac;
         default: sel_word = sp;
      endcase
   end

   assign sel_byte = sel_high ? sel_word[`REG_WIDTH-1:`BYTE_WIDTH]
                              : sel_word[`BYTE_WIDTH-1:0];

   ////////////////////////////////////////////////////////////
   // Handshake FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         state  <= reg_board_pkg::FP_IDLE;
         fp_ack <= 1'b0;
         fpd    <= '0;
      end else begin
         case (state)
            reg_board_pkg::FP_IDLE: begin
               if (fp_req) begin
                  fpd    <= sel_byte;            // Snapshot taken once per request
                  fp_ack <= 1'b1;
                  state  <= reg_board_pkg::FP_HOLD;
               end
            end
            reg_board_pkg::FP_HOLD: begin
               if (!fp_req) begin
                  fp_ack <= 1'b0;                // Host let go, drop ack
                  state  <= reg_board_pkg::FP_RELEASE;
               end
            end
            default: begin
               state <= reg_board_pkg::FP_IDLE; // Ack now low, reopen for requests
            end
         endcase
      end
   end

endmodule

// ==== hdl/major_register.sv ====
// Major register
// One bus-loadable word with increment, decrement and a zero flag
`timescale 1ns/1ps

module major_register (
   input  logic                 clk4,       // Write phase clock
   input  logic                 rst_n,      // Synchronous, active low
   input  reg_board_pkg::word_t ibus_in,    // Processor bus value
   input  logic                 write_en,   // Load from the bus
   input  logic                 inc_en,     // Count up
   input  logic                 dec_en,     // Count down
   output reg_board_pkg::word_t value,      // Current contents
   output logic                 zero        // Contents are all zero
);

   reg_board_pkg::word_t value_q;

   ////////////////////////////////////////////////////////////
   // Register update
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         value_q <= '0;
      end else if (write_en) begin
         value_q <= ibus_in;                    // Bus write wins over actions
      end else if (inc_en) begin
         value_q <= value_q + 1'b1;             // Wraps at 0xFFFF
      end else if (dec_en) begin
         value_q <= value_q - 1'b1;             // Wraps at 0x0000
      end
   end

   // Outputs come straight off the flops
   assign value = value_q;
   assign zero  = (value_q == '0);            // Flag used only by AC

endmodule

// ==== hdl/microcode_decoder.sv ====
// Microcode decoder
// Turns read/write addresses and the action code into register strobes
`timescale 1ns/1ps
`include "reg_board_settings.svh"

module microcode_decoder (
   input  reg_board_pkg::addr_t   raddr,      // Register to drive the bus
   input  reg_board_pkg::addr_t   waddr,      // Register to load from the bus
   input  reg_board_pkg::action_t action,     // Increment/decrement code
   output reg_board_pkg::strobe_t read_stb,
   output reg_board_pkg::strobe_t write_stb,
   output reg_board_pkg::strobe_t inc_stb,
   output reg_board_pkg::strobe_t dec_stb
);

   localparam reg_board_pkg::reg_idx_t IDX_PC = 0;  // PC only has an increment

   // Address window 8..11 maps onto one strobe bit, anything else on none
   function automatic reg_board_pkg::strobe_t addr_decode(input reg_board_pkg::addr_t addr);
      reg_board_pkg::addr_t  offset;
      reg_board_pkg::strobe_t stb;
      offset = addr - reg_board_pkg::addr_t'(`REG_ADDR_BASE);  // Wraps high below base
      stb    = '0;
      if (offset < reg_board_pkg::addr_t'(`REG_COUNT)) begin
         stb[reg_board_pkg::reg_idx_t'(offset)] = 1'b1;
      end
      return stb;
   endfunction

   ////////////////////////////////////////////////////////////
   // Read and write decoders
   ////////////////////////////////////////////////////////////

   assign read_stb  = addr_decode(raddr);     // Same decode, as with twin 138s
   assign write_stb = addr_decode(waddr);

   ////////////////////////////////////////////////////////////
   // Action decoder
   ////////////////////////////////////////////////////////////

   always_comb begin
      reg_board_pkg::action_t  act_off;
      reg_board_pkg::reg_idx_t act_reg;
      inc_stb = '0;
      dec_stb = '0;
      act_off = action - reg_board_pkg::action_t'(`ACTION_BASE);
      act_reg = act_off[2:1];                   // Pairs 10/11, 12/13, 14/15
      if (action >= reg_board_pkg::action_t'(`ACTION_BASE)) begin
         if (act_off == '0) begin
            inc_stb[IDX_PC] = 1'b1;             // Code 8, increment PC
         end else if (act_off != reg_board_pkg::action_t'(1)) begin
            if (act_off[0]) begin
               dec_stb[act_reg] = 1'b1;         // Odd codes decrement
            end else begin
               inc_stb[act_reg] = 1'b1;         // Even codes increment
            end
         end
         // Code 9 is unused, no strobe
      end
   end

endmodule

// ==== hdl/reg_board.sv ====
// Register board top level
// Microcode decode, four major registers, bus read mux and front panel
`timescale 1ns/1ps
`include "reg_board_settings.svh"

module reg_board (
   input  logic                    clk4,        // Write phase clock
   input  logic                    rst_n,       // Synchronous, active low
   input  reg_board_pkg::addr_t    raddr,       // Microcode read address
   input  reg_board_pkg::addr_t    waddr,       // Microcode write address
   input  reg_board_pkg::action_t  action,      // Microcode action code
   input  reg_board_pkg::word_t    ibus_in,     // Processor bus, inbound
   input  logic                    fp_req,      // Front panel request
   input  reg_board_pkg::fp_sel_t  fp_sel,      // Front panel byte select
   output reg_board_pkg::word_t    ibus_out,    // Processor bus, outbound
   output logic                    ibus_drive,  // Board is driving the bus
   output reg_board_pkg::word_t    pc_out,
   output reg_board_pkg::word_t    ac_out,
   output logic                    fz,          // AC is zero
   output logic                    fp_ack,      // Front panel acknowledge
   output reg_board_pkg::byte_t    fpd          // Front panel data
);

   reg_board_pkg::strobe_t read_stb;
   reg_board_pkg::strobe_t write_stb;
   reg_board_pkg::strobe_t inc_stb;
   reg_board_pkg::strobe_t dec_stb;

   reg_board_pkg::word_t   pc, dr, ac, sp;
   reg_board_pkg::word_t   reg_val [`REG_COUNT];

   ////////////////////////////////////////////////////////////
   // Decoders
   ////////////////////////////////////////////////////////////

   microcode_decoder u_decoder (
      .raddr     (raddr),
      .waddr     (waddr),
      .action    (action),
      .read_stb  (read_stb),
      .write_stb (write_stb),
      .inc_stb   (inc_stb),
      .dec_stb   (dec_stb)
   );

   ////////////////////////////////////////////////////////////
   // Major registers
   ////////////////////////////////////////////////////////////

   // PC, increment only, decrement strobe never set
   major_register u_pc (
      .clk4 (clk4), .rst_n (rst_n), .ibus_in (ibus_in),
      .write_en (write_stb[0]), .inc_en (inc_stb[0]), .dec_en (dec_stb[0]),
      .value (pc), .zero ()
   );

   major_register u_dr (                        // DR, increment and decrement
      .clk4 (clk4), .rst_n (rst_n), .ibus_in (ibus_in),
      .write_en (write_stb[1]), .inc_en (inc_stb[1]), .dec_en (dec_stb[1]),
      .value (dr), .zero ()
   );

   major_register u_ac (                        // AC, the only flag user
      .clk4 (clk4), .rst_n (rst_n), .ibus_in (ibus_in),
      .write_en (write_stb[2]), .inc_en (inc_stb[2]), .dec_en (dec_stb[2]),
      .value (ac), .zero (fz)
   );

   major_register u_sp (                        // SP, increment and decrement
      .clk4 (clk4), .rst_n (rst_n), .ibus_in (ibus_in),
      .write_en (write_stb[3]), .inc_en (inc_stb[3]), .dec_en (dec_stb[3]),
      .value (sp), .zero ()
   );

   ////////////////////////////////////////////////////////////
   // Bus read mux and exports
   ////////////////////////////////////////////////////////////

   assign reg_val[0] = pc;
   assign reg_val[1] = dr;
   assign reg_val[2] = ac;
   assign reg_val[3] = sp;

   always_comb begin
      ibus_out = '0;                            // Zero when nothing is selected
      for (int i = 0; i < `REG_COUNT; i++) begin
         if (read_stb[i]) begin
            ibus_out = ibus_out | reg_val[i];  // Strobe is one-hot or zero
         end
      end
   end

   assign ibus_drive = |read_stb;               // Stands in for the tri-state enable
   assign pc_out     = pc;
   assign ac_out     = ac;

   front_panel_port u_front_panel (
      .clk4   (clk4),
      .rst_n  (rst_n),
      .fp_req (fp_req),
      .fp_sel (fp_sel),
      .pc     (pc),
      .dr     (dr),
      .ac     (ac),
      .sp     (sp),
      .fp_ack (fp_ack),
      .fpd    (fpd)
   );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the register board testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module reg_board_tb \
   -f build.f

# The log decides the result, a fatal exit still reaches the search below
./obj_dir/Vreg_board_tb 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi

if ! grep -q "Test passed" sim.log; then
   echo "Simulation ended without a result, see sim.log"
   exit 1
fi

echo "Simulation passed"

// ==== tb/reg_board_assert.sv ====
// Register board assertions
// Front panel handshake and decoder strobe rules, bound into the top level
`timescale 1ns/1ps

module reg_board_assert (
   input logic                   clk4,
   input logic                   rst_n,
   input logic                   fp_req,
   input logic                   fp_ack,
   input reg_board_pkg::byte_t   fpd,
   input reg_board_pkg::addr_t   raddr,
   input logic                   ibus_drive,
   input reg_board_pkg::strobe_t read_stb,
   input reg_board_pkg::strobe_t write_stb,
   input reg_board_pkg::strobe_t inc_stb,
   input reg_board_pkg::strobe_t dec_stb
);

   // Ack goes up only in answer to a request
   ack_needs_req: assert property (@(posedge clk4) disable iff (!rst_n)
      $rose(fp_ack) |-> $past(fp_req))
      else $error("fp_ack rose without fp_req");

   // Snapshot frozen for the whole ack window
   fpd_held: assert property (@(posedge clk4) disable iff (!rst_n)
      (fp_ack && $past(fp_ack)) |-> $stable(fpd))
      else $error("fpd changed while fp_ack high");

   strobes_onehot: assert property (@(posedge clk4) disable iff (!rst_n)
      $onehot0(read_stb) && $onehot0(write_stb) && $onehot0(inc_stb) && $onehot0(dec_stb))
      else $error("decoder strobe not one-hot or zero");

   drive_in_window: assert property (@(posedge clk4) disable iff (!rst_n)
      (raddr < 5'd8 || raddr > 5'd11) |-> !ibus_drive)
      else $error("ibus_drive high outside addresses 8 to 11");

endmodule

bind reg_board reg_board_assert u_assert (
   .clk4 (clk4), .rst_n (rst_n), .fp_req (fp_req), .fp_ack (fp_ack), .fpd (fpd),
   .raddr (raddr), .ibus_drive (ibus_drive), .read_stb (read_stb),
   .write_stb (write_stb), .inc_stb (inc_stb), .dec_stb (dec_stb)
);

// ==== tb/reg_board_tb.sv ====
// Register board testbench
// Table, front panel and LFSR phases checked against a reference model
`timescale 1ns/1ps
`include "reg_board_settings.svh"

module reg_board_tb;

   localparam int ACK_TIMEOUT = 20;           // Cycles allowed per handshake phase
   localparam int RAND_CYCLES = 400;

   typedef struct packed {
      reg_board_pkg::addr_t   raddr;
      reg_board_pkg::addr_t   waddr;
      reg_board_pkg::action_t action;
      reg_board_pkg::word_t   ibus_in;
      reg_board_pkg::word_t   exp_out;
      logic                   exp_drive;
      reg_board_pkg::word_t   exp_pc;
      reg_board_pkg::word_t   exp_ac;
   } row_t;

   logic                   clk4 = 1'b0;
   logic                   rst_n;
   reg_board_pkg::addr_t   raddr, waddr;
   reg_board_pkg::action_t action;
   reg_board_pkg::word_t   ibus_in, ibus_out, pc_out, ac_out;
   logic                   ibus_drive, fz, fp_req, fp_ack;
   reg_board_pkg::fp_sel_t fp_sel;
   reg_board_pkg::byte_t   fpd;

   row_t                   stim_rows [$];
   reg_board_pkg::word_t   model [`REG_COUNT];   // Reference PC, DR, AC, SP
   logic [31:0]            lfsr_state = 32'd77138;
   logic [31:0]            bits;

   always #4 clk4 = ~clk4;                    // 8 ns period

   reg_board u_dut (
      .clk4 (clk4), .rst_n (rst_n), .raddr (raddr), .waddr (waddr),
      .action (action), .ibus_in (ibus_in), .fp_req (fp_req), .fp_sel (fp_sel),
      .ibus_out (ibus_out), .ibus_drive (ibus_drive), .pc_out (pc_out),
      .ac_out (ac_out), .fz (fz), .fp_ack (fp_ack), .fpd (fpd)
   );

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input reg_board_pkg::word_t act,
                             input reg_board_pkg::word_t exp);
      if (act !== exp) begin
         $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
         $display("Test failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic check_byte(input string name, input reg_board_pkg::byte_t act,
                             input reg_board_pkg::byte_t exp);
      if (act !== exp) begin
         $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
         $display("Test failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic check_bit(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
         $display("Test failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model and random source
   ////////////////////////////////////////////////////////////

   function automatic int reg_of(input reg_board_pkg::addr_t a);
      if (a >= 5'd8 && a <= 5'd11) begin
         return int'(a) - 8;                  // 8 PC, 9 DR, 10 AC, 11 SP
      end
      return -1;
   endfunction

   task automatic model_update(input reg_board_pkg::addr_t wa,
                               input reg_board_pkg::action_t act,
                               input reg_board_pkg::word_t din);
      int   wi;
      int   ai;
      logic up;
      wi = reg_of(wa);
      ai = -1;
      up = 1'b1;
      if (act == 4'd8) begin
         ai = 0;                              // PC increment only
      end else if (act >= 4'd10) begin
         ai = (int'(act) - 8) / 2;            // Even codes up and odd codes down
         up = !act[0];
      end
      if (ai >= 0 && ai != wi) begin
         model[ai] = up ? model[ai] + 16'd1 : model[ai] - 16'd1;
      end
      if (wi >= 0) begin
         model[wi] = din;                     // Write beats the action
      end
   endtask

   function automatic reg_board_pkg::byte_t panel_byte(input reg_board_pkg::fp_sel_t sel);
      reg_board_pkg::word_t w;
      w = model[sel[1:0]];
      return sel[2] ? w[15:8] : w[7:0];
   endfunction

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] val);
      val = '0;
      repeat (n) begin
         lfsr_state = lfsr_step(lfsr_state);
         val        = {val[30:0], lfsr_state[0]};
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   task automatic add_row(input reg_board_pkg::addr_t ra, input reg_board_pkg::addr_t wa,
                          input reg_board_pkg::action_t act, input reg_board_pkg::word_t din,
                          input reg_board_pkg::word_t dout, input logic drv,
                          input reg_board_pkg::word_t pc, input reg_board_pkg::word_t ac);
      stim_rows.push_back('{ra, wa, act, din, dout, drv, pc, ac});
   endtask

   task automatic build_table();
      // raddr, waddr, action, ibus_in, exp ibus_out, exp drive, exp pc, exp ac
      add_row(5'd8,  5'd0,  4'd0,  16'h0000, 16'h0000, 1'b1, 16'h0000, 16'h0000);
      add_row(5'd9,  5'd0,  4'd0,  16'h0000, 16'h0000, 1'b1, 16'h0000, 16'h0000);
      add_row(5'd10, 5'd0,  4'd0,  16'h0000, 16'h0000, 1'b1, 16'h0000, 16'h0000);
      add_row(5'd11, 5'd0,  4'd0,  16'h0000, 16'h0000, 1'b1, 16'h0000, 16'h0000);
      add_row(5'd0,  5'd8,  4'd0,  16'h1234, 16'h0000, 1'b0, 16'h0000, 16'h0000);
      add_row(5'd8,  5'd9,  4'd0,  16'h5678, 16'h1234, 1'b1, 16'h1234, 16'h0000);
      add_row(5'd9,  5'd10, 4'd0,  16'hFFFF, 16'h5678, 1'b1, 16'h1234, 16'h0000);
      add_row(5'd10, 5'd11, 4'd0,  16'h0001, 16'hFFFF, 1'b1, 16'h1234, 16'hFFFF);
      add_row(5'd11, 5'd31, 4'd0,  16'hAAAA, 16'h0001, 1'b1, 16'h1234, 16'hFFFF);
      add_row(5'd12, 5'd7,  4'd0,  16'hBBBB, 16'h0000, 1'b0, 16'h1234, 16'hFFFF);
      add_row(5'd7,  5'd0,  4'd12, 16'h0000, 16'h0000, 1'b0, 16'h1234, 16'hFFFF);
      add_row(5'd10, 5'd0,  4'd13, 16'h0000, 16'h0000, 1'b1, 16'h1234, 16'h0000);
      add_row(5'd10, 5'd0,  4'd9,  16'h0000, 16'hFFFF, 1'b1, 16'h1234, 16'hFFFF);
      add_row(5'd10, 5'd0,  4'd5,  16'h0000, 16'hFFFF, 1'b1, 16'h1234, 16'hFFFF);
      add_row(5'd11, 5'd0,  4'd15, 16'h0000, 16'h0001, 1'b1, 16'h1234, 16'hFFFF);
      add_row(5'd11, 5'd0,  4'd15, 16'h0000, 16'h0000, 1'b1, 16'h1234, 16'hFFFF);
      add_row(5'd11, 5'd0,  4'd14, 16'h0000, 16'hFFFF, 1'b1, 16'h1234, 16'hFFFF);
      add_row(5'd8,  5'd0,  4'd8,  16'h0000, 16'h1234, 1'b1, 16'h1234, 16'hFFFF);
      add_row(5'd9,  5'd0,  4'd10, 16'h0000, 16'h5678, 1'b1, 16'h1235, 16'hFFFF);
      add_row(5'd9,  5'd0,  4'd11, 16'h0000, 16'h5679, 1'b1, 16'h1235, 16'hFFFF);
      add_row(5'd9,  5'd9,  4'd10, 16'h0100, 16'h5678, 1'b1, 16'h1235, 16'hFFFF);
      add_row(5'd9,  5'd10, 4'd13, 16'h8000, 16'h0100, 1'b1, 16'h1235, 16'hFFFF);
      add_row(5'd10, 5'd8,  4'd8,  16'h0042, 16'h8000, 1'b1, 16'h1235, 16'h8000);
      add_row(5'd8,  5'd11, 4'd14, 16'hFFFF, 16'h0042, 1'b1, 16'h0042, 16'h8000);
      add_row(5'd11, 5'd0,  4'd0,  16'h0000, 16'hFFFF, 1'b1, 16'h0042, 16'h8000);
   endtask

   task automatic wait_ack(input logic level, input string what);
      int cycles;
      cycles = 0;
      while (fp_ack !== level) begin
         if (cycles == ACK_TIMEOUT) begin
            $display("Timeout: fp_ack never went to %0d while waiting for %s", level, what);
            $display("Test failed");
            $fatal(1, "Handshake timeout");
         end else begin
            @(posedge clk4);
            #1;
            cycles++;
         end
      end
   endtask

   // One full four-phase read with PC counted up while the request is held
   task automatic fp_read(input reg_board_pkg::fp_sel_t sel, input int hold_incs);
      reg_board_pkg::byte_t expected;
      expected = panel_byte(sel);
      @(negedge clk4);
      fp_sel = sel;
      fp_req = 1'b1;
      wait_ack(1'b1, "request accept");
      check_byte("fpd", fpd, expected);
      repeat (hold_incs) begin
         @(negedge clk4);
         action = 4'd8;
         model_update(5'd0, 4'd8, 16'h0000);
         @(posedge clk4);
         #1;
         check_word("pc_out", pc_out, model[0]);  // Count landed under the held request
         check_bit("fp_ack", fp_ack, 1'b1);
         check_byte("fpd", fpd, expected);        // Snapshot frozen
      end
      @(negedge clk4);
      action = 4'd0;
      fp_req = 1'b0;
      wait_ack(1'b0, "ack release");
      check_word("pc_out", pc_out, model[0]);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rst_n   = 1'b0;
      raddr   = '0;
      waddr   = '0;
      action  = '0;
      ibus_in = '0;
      fp_req  = 1'b0;
      fp_sel  = '0;
      build_table();
      repeat (10) @(posedge clk4);
      @(negedge clk4);
      rst_n = 1'b1;
      #2;
      check_bit("fz", fz, 1'b1);             // AC cleared by reset
      check_bit("fp_ack", fp_ack, 1'b0);
      check_byte("fpd", fpd, 8'h00);

      foreach (stim_rows[i]) begin
         @(negedge clk4);
         raddr   = stim_rows[i].raddr;
         waddr   = stim_rows[i].waddr;
         action  = stim_rows[i].action;
         ibus_in = stim_rows[i].ibus_in;
         #2;                                  // Settle before sampling
         check_word("ibus_out", ibus_out, stim_rows[i].exp_out);
         check_bit("ibus_drive", ibus_drive, stim_rows[i].exp_drive);
         check_word("pc_out", pc_out, stim_rows[i].exp_pc);
         check_word("ac_out", ac_out, stim_rows[i].exp_ac);
         check_bit("fz", fz, stim_rows[i].exp_ac == 16'h0000);
      end

      @(negedge clk4);
      raddr   = '0;
      waddr   = '0;
      action  = '0;
      ibus_in = '0;
      model[0] = 16'h0042;                    // State left by the table
      model[1] = 16'h0100;
      model[2] = 16'h8000;
      model[3] = 16'hFFFF;

      for (int i = 0; i < 8; i++) begin
         fp_read(reg_board_pkg::fp_sel_t'(i), 0);  // Both bytes of every register
      end
      fp_read(3'd0, 3);                       // PC low byte counted up while held

      for (int n = 0; n < RAND_CYCLES; n++) begin
         @(negedge clk4);
         rand_bits(5, bits);
         raddr = reg_board_pkg::addr_t'(bits[4:0]);
         rand_bits(4, bits);
         waddr = 5'd4 + reg_board_pkg::addr_t'(bits[3:0]);  // 4..19 hits more registers
         rand_bits(4, bits);
         action = reg_board_pkg::action_t'(bits[3:0]);
         rand_bits(16, bits);
         ibus_in = reg_board_pkg::word_t'(bits[15:0]);
         #2;
         check_bit("ibus_drive", ibus_drive, reg_of(raddr) >= 0);
         check_word("ibus_out", ibus_out,
                    (reg_of(raddr) >= 0) ? model[reg_of(raddr)] : 16'h0000);
         check_word("pc_out", pc_out, model[0]);
         check_word("ac_out", ac_out, model[2]);
         check_bit("fz", fz, model[2] == 16'h0000);
         model_update(waddr, action, ibus_in);
      end

      $display("Test passed");
      $finish;
   end

endmodule
